//--- dc_pkg.sv
package dc_pkg;

   // Payload word equals the AXI data width
   localparam int DW = 32;
   localparam int DW_BYTES_LOG2 = 2;

   typedef logic [DW-1:0] dc_word_t;

   typedef enum logic [2:0]
   {
      S_BOOT,
      S_IDLE,
      S_REFILL,
      S_REPLAY,       // Re-read of the held request after a refill
      S_INVALIDATE
   } dc_state_e;

   // Tag bits left above set index and line offset
   function automatic int tag_width(int aw, int p_sets, int p_line);
      return aw - p_sets - p_line;
   endfunction

   // Words per line, also the length of one refill burst
   function automatic int words_per_line(int p_line);
      return 1 << (p_line - DW_BYTES_LOG2);
   endfunction

endpackage

//--- dc_sram.sv
`timescale 1ns/1ps

module dc_sram
#(
   parameter type entry_t = logic [31:0],
   parameter int DEPTH_LOG2 = 6
)
(
   input  logic                  clk,
   input  logic                  re_i,
   input  logic                  we_i,
   input  logic [DEPTH_LOG2-1:0] addr_i,
   input  entry_t                din_i,
   output entry_t                dout_o
);

   entry_t mem [2**DEPTH_LOG2];

   // Write goes to the array only
   always_ff @(posedge clk)
   begin
      if (we_i)
         mem[addr_i] <= din_i;
   end

   // Registered read that holds while re_i is low
   always_ff @(posedge clk)
   begin
      if (re_i)
         dout_o <= mem[addr_i];
   end

endmodule

//--- dc_ctrl_fsm.sv
`timescale 1ns/1ps

module dc_ctrl_fsm
   import dc_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n_i,
   input  logic      lookup_valid_i,  // Compare stage holds a read
   input  logic      hit_i,
   input  logic      inv_i,           // Compare stage holds an invalidate
   input  logic      sweep_done_i,
   input  logic      beat_i,
   input  logic      last_beat_i,
   output dc_state_e state_o,
   output logic      stall_o,
   output logic      refill_start_o,
   output logic      sweep_en_o,
   output logic      beat_clr_o
);

   dc_state_e state_d;
   logic      miss;

   assign miss = lookup_valid_i & ~hit_i & ~inv_i;

   always_comb
   begin
      state_d = state_o;
      case (state_o)
         S_BOOT:
            if (sweep_done_i)
               state_d = S_IDLE;
         S_IDLE:
         begin
            if (inv_i)
               state_d = S_INVALIDATE;
            else if (miss)
               state_d = S_REFILL;
         end
         S_REFILL:
            if (beat_i && last_beat_i)
               state_d = S_REPLAY;
         S_REPLAY,
         S_INVALIDATE:
            state_d = S_IDLE;
         default:
            state_d = S_BOOT;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         state_o <= S_BOOT;
      else
         state_o <= state_d;
   end

   // Everything but IDLE blocks new requests
   assign stall_o        = (state_o != S_IDLE);
   assign refill_start_o = (state_o == S_IDLE) & miss;
   assign sweep_en_o     = (state_o == S_BOOT);
   assign beat_clr_o     = (state_o != S_REFILL); // Beat count restarts each refill

endmodule

//--- dc_line_counter.sv
`timescale 1ns/1ps

module dc_line_counter
   import dc_pkg::*;
#(
   parameter int P_SETS = 6,
   parameter int P_LINE = 4
)
(
   input  logic                            clk,
   input  logic                            arst_n_i,
   input  logic                            sweep_en_i,
   input  logic                            beat_i,
   input  logic                            beat_clr_i,
   output logic [P_SETS-1:0]               sweep_idx_o,
   output logic                            sweep_done_o,
   output logic [P_LINE-DW_BYTES_LOG2-1:0] beat_idx_o,
   output logic                            last_beat_o
);

   localparam int WI = P_LINE - DW_BYTES_LOG2;
   localparam logic [WI-1:0] LAST_IDX = WI'(words_per_line(P_LINE) - 1);

   // Set walk for the boot sweep
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         sweep_idx_o <= '0;
      else if (sweep_en_i)
         sweep_idx_o <= sweep_idx_o + 1'b1;
   end

   // Accepted R beats of the current line
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         beat_idx_o <= '0;
      else if (beat_clr_i)
         beat_idx_o <= '0;
      else if (beat_i)
         beat_idx_o <= beat_idx_o + 1'b1;
   end

   assign sweep_done_o = &sweep_idx_o;
   assign last_beat_o  = (beat_idx_o == LAST_IDX);

endmodule

//--- dc_axi_rd.sv
`timescale 1ns/1ps

module dc_axi_rd
#(
   parameter int AW = 32
)
(
   input  logic          clk,
   input  logic          arst_n_i,
   input  logic          start_i,
   input  logic [AW-1:0] line_addr_i,
   input  logic          refill_i,
   // AR channel
   input  logic          ar_ready_i,
   output logic          ar_valid_o,
   output logic [AW-1:0] ar_addr_o,
   // R channel
   input  logic          r_valid_i,
   output logic          r_ready_o,
   output logic          beat_o
);

   logic ar_hs;

   assign ar_hs = ar_valid_o & ar_ready_i;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         ar_valid_o <= 1'b0;
      else if (start_i)
         ar_valid_o <= 1'b1;
      else if (ar_hs)
         ar_valid_o <= 1'b0;
   end

   // Line address stays put until the slave takes it
   always_ff @(posedge clk)
   begin
      if (start_i)
         ar_addr_o <= line_addr_i;
   end

   assign r_ready_o = refill_i;
   assign beat_o    = r_valid_i & r_ready_o;

endmodule

//--- dcache.sv
`timescale 1ns/1ps

module dcache
   import dc_pkg::*;
#(
   parameter int AW     = 32,
   parameter int P_SETS = 6,
   parameter int P_LINE = 4
)
(
   input  logic          clk,
   input  logic          arst_n_i,
   input  logic          req_i,
   input  logic [AW-1:0] addr_i,
   input  logic          inv_i,
   input  logic [AW-1:0] inv_addr_i,
   output logic          stall_o,
   output dc_word_t      dout_o,
   output logic          valid_o,
   // AXI read master
   output logic          ar_valid_o,
   input  logic          ar_ready_i,
   output logic [AW-1:0] ar_addr_o,
   input  logic          r_valid_i,
   output logic          r_ready_o,
   input  dc_word_t      r_data_i
);

   localparam int TAG_W   = tag_width(AW, P_SETS, P_LINE);
   localparam int WI      = P_LINE - DW_BYTES_LOG2;
   localparam int DATA_AW = P_SETS + WI;

   typedef struct packed
   {
      logic [TAG_W-1:0] tag;
      logic             valid;
   } tag_entry_t;

   dc_state_e           state;
   logic                s1_valid, s1_inv, s1_kill;
   logic [AW-1:0]       s1_addr;
   logic                s2_valid;
   logic [AW-1:0]       s2_addr;
   logic [AW-1:0]       req_addr;
   logic [AW-1:0]       line_addr;
   logic                ram_re, hit;
   logic [P_SETS-1:0]   tag_addr;
   logic                tag_we;
   tag_entry_t          tag_din, tag_dout;
   logic [DATA_AW-1:0]  data_addr;
   dc_word_t            data_dout;
   logic [P_SETS-1:0]   sweep_idx;
   logic                sweep_done, sweep_en;
   logic [WI-1:0]       beat_idx;
   logic                beat, last_beat, beat_clr, refill_start;

   // Both pipeline stages advance together
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         s1_valid <= 1'b0;
         s1_inv   <= 1'b0;
         s2_valid <= 1'b0;
      end
      else if (!stall_o)
      begin
         s1_valid <= req_i;
         s1_inv   <= inv_i;
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!stall_o)
      begin
         s1_addr <= inv_i ? inv_addr_i : addr_i; // One address serves both ops
         s2_addr <= s1_addr;
      end
   end

   // Tag of the held read was fetched before the invalidate hit the RAM
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         s1_kill <= 1'b0;
      else if (state == S_INVALIDATE)
         s1_kill <= (s1_addr[P_LINE +: P_SETS] == s2_addr[P_LINE +: P_SETS]);
      else if (!stall_o)
         s1_kill <= 1'b0;
   end

   // Replay re-reads for the held request
   assign req_addr = (state == S_REPLAY) ? s1_addr : addr_i;
   assign ram_re   = (state == S_IDLE) | (state == S_REPLAY);

   always_comb
   begin
      case (state)
         S_BOOT:
            tag_addr = sweep_idx;
         S_REFILL,
         S_INVALIDATE:
            tag_addr = s2_addr[P_LINE +: P_SETS];
         default:
            tag_addr = req_addr[P_LINE +: P_SETS];
      endcase
   end

   assign tag_we        = (state == S_BOOT) | (state == S_INVALIDATE) | (state == S_REFILL);
   assign tag_din.tag   = s2_addr[AW-1 -: TAG_W];
   assign tag_din.valid = (state == S_REFILL);

   assign data_addr = (state == S_REFILL) ? {s2_addr[P_LINE +: P_SETS], beat_idx}
                                          : req_addr[DW_BYTES_LOG2 +: DATA_AW];

   assign hit = tag_dout.valid & ~s1_kill & (tag_dout.tag == s1_addr[AW-1 -: TAG_W]);

   // Output word from the RAM on a hit, or from the passing R beat
   always_ff @(posedge clk)
   begin
      if (!stall_o && s1_valid && hit)
         dout_o <= data_dout;
      else if (beat && (beat_idx == s2_addr[DW_BYTES_LOG2 +: WI]))
         dout_o <= r_data_i;
   end

   assign valid_o   = s2_valid & ~stall_o;
   assign line_addr = {s1_addr[AW-1:P_LINE], {P_LINE{1'b0}}};

   dc_ctrl_fsm u_ctrl_fsm
   (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .lookup_valid_i (s1_valid),
      .hit_i          (hit),
      .inv_i          (s1_inv),
      .sweep_done_i   (sweep_done),
      .beat_i         (beat),
      .last_beat_i    (last_beat),
      .state_o        (state),
      .stall_o        (stall_o),
      .refill_start_o (refill_start),
      .sweep_en_o     (sweep_en),
      .beat_clr_o     (beat_clr)
   );

   dc_line_counter #(.P_SETS(P_SETS), .P_LINE(P_LINE)) u_line_counter
   (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .sweep_en_i   (sweep_en),
      .beat_i       (beat),
      .beat_clr_i   (beat_clr),
      .sweep_idx_o  (sweep_idx),
      .sweep_done_o (sweep_done),
      .beat_idx_o   (beat_idx),
      .last_beat_o  (last_beat)
   );

   dc_axi_rd #(.AW(AW)) u_axi_rd
   (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .start_i     (refill_start),
      .line_addr_i (line_addr),
      .refill_i    (state == S_REFILL),
      .ar_ready_i  (ar_ready_i),
      .ar_valid_o  (ar_valid_o),
      .ar_addr_o   (ar_addr_o),
      .r_valid_i   (r_valid_i),
      .r_ready_o   (r_ready_o),
      .beat_o      (beat)
   );

   dc_sram #(.entry_t(tag_entry_t), .DEPTH_LOG2(P_SETS)) u_tag_ram
   (
      .clk    (clk),
      .re_i   (ram_re),
      .we_i   (tag_we),
      .addr_i (tag_addr),
      .din_i  (tag_din),
      .dout_o (tag_dout)
   );

   dc_sram #(.entry_t(dc_word_t), .DEPTH_LOG2(DATA_AW)) u_data_ram
   (
      .clk    (clk),
      .re_i   (ram_re),
      .we_i   (beat),         // One word per accepted beat
      .addr_i (data_addr),
      .din_i  (r_data_i),
      .dout_o (data_dout)
   );

endmodule

//--- tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem
#(
   parameter int WORDS     = 4,
   parameter int LINE_LOG2 = 4,
   parameter int SEED      = 48509
)
(
   input  logic        clk,
   input  logic        stall_en_i,
   input  logic        ar_valid_i,
   output logic        ar_ready_o,
   input  logic [31:0] ar_addr_i,
   output logic        r_valid_o,
   input  logic        r_ready_i,
   output logic [31:0] r_data_o
);

   localparam logic [31:0] MULT = 32'h9E37_79B1;

   int          seed = SEED;
   int          gen [1024];    // Generation per line
   logic        busy;
   logic        ar_hs;
   logic        r_hs;
   logic [31:0] line;
   int          beat;

   // Makes cached copies of a line stale
   task automatic bump_gen(input logic [31:0] addr);
      gen[addr[LINE_LOG2 +: 10]] = gen[addr[LINE_LOG2 +: 10]] + 1;
   endtask

   initial
   begin
      busy       = 1'b0;
      beat       = 0;
      line       = '0;
      ar_ready_o = 1'b0;
      r_valid_o  = 1'b0;
      r_data_o   = '0;
      forever
      begin
         @(negedge clk);
         ar_hs = ar_valid_i & ar_ready_o;
         r_hs  = r_valid_o & r_ready_i;
         if (ar_hs)
            line = ar_addr_i;
         @(posedge clk);
         #1;
         if (ar_hs)
         begin
            busy = 1'b1;
            beat = 0;
         end
         else if (r_hs)
         begin
            beat = beat + 1;
            if (beat == WORDS)
               busy = 1'b0;
         end
         // Random gaps on both channels when stalls are on
         ar_ready_o = !busy && (!stall_en_i || (($random(seed) & 1) != 0));
         r_valid_o  = busy && (!stall_en_i || (($random(seed) & 1) != 0));
         r_data_o   = (line + 32'(beat * 4)) * MULT + 32'(gen[line[LINE_LOG2 +: 10]]);
      end
   end

endmodule

//--- tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

   localparam int AW        = 32;
   localparam int P_SETS    = 6;
   localparam int P_LINE    = 4;
   localparam int SETS      = 1 << P_SETS;
   localparam int WPL       = 1 << (P_LINE - 2);
   localparam int PERIOD    = 4;
   localparam int N_RAND    = 200;
   localparam int N_REQ     = 2 * N_RAND + 16;
   localparam int MAX_STALL = 4;
   localparam logic [31:0] BASE = 32'h0000_1000;
   localparam logic [31:0] MULT = 32'h9E37_79B1;

   logic          clk;
   logic          arst_n_i;
   logic          req_i;
   logic [AW-1:0] addr_i;
   logic          inv_i;
   logic [AW-1:0] inv_addr_i;
   logic          stall_o;
   logic [31:0]   dout_o;
   logic          valid_o;
   logic          ar_valid_o;
   logic          ar_ready_i;
   logic [AW-1:0] ar_addr_o;
   logic          r_valid_i;
   logic          r_ready_o;
   logic [31:0]   r_data_i;
   logic          stall_en;

   int                  seed = 48509;
   int                  errors = 0;
   int                  ar_count = 0;
   int                  results = 0;
   int                  reads = 0;
   int                  misses = 0;    // Predicted AR bursts
   int                  boot_cycles = 0;
   logic [31:0]         exp_q [$];
   logic [31:0]         exp_word;
   int                  gen_ref [1024];
   bit                  tag_valid [SETS];
   logic [AW-P_LINE-1:0] tag_line [SETS];
   int                  tag_gen [SETS];   // Generation the cached copy was filled with
   bit                  ar_wait = 1'b0;
   logic [AW-1:0]       ar_prev;
   logic [AW-1:0]       ar_last;

   dcache #(.AW(AW), .P_SETS(P_SETS), .P_LINE(P_LINE)) i_dcache (.*);

   tb_axi_mem #(.WORDS(WPL), .LINE_LOG2(P_LINE)) i_axi_mem
   (
      .clk        (clk),
      .stall_en_i (stall_en),
      .ar_valid_i (ar_valid_o),
      .ar_ready_o (ar_ready_i),
      .ar_addr_i  (ar_addr_o),
      .r_valid_o  (r_valid_i),
      .r_ready_i  (r_ready_o),
      .r_data_o   (r_data_i)
   );

   // Memory word at byte address a for generation g
   function automatic logic [31:0] ref_word(input logic [31:0] a, input int g);
      return {a[31:2], 2'b00} * MULT + 32'(g);
   endfunction

   initial
   begin
      clk = 1'b0;
      forever
         #(PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      #(N_REQ * (WPL + 10) * MAX_STALL * PERIOD + (SETS + 5) * PERIOD);
      $display("Timeout: the cache stopped answering before all tests finished");
      $display(">>> FAIL");
      $finish;
   end

   // Results come back in request order
   always @(negedge clk)
   begin
      if (valid_o)
      begin
         results++;
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("valid_o went high at %0t with no read outstanding", $time);
         end
         else
         begin
            exp_word = exp_q.pop_front();
            if (dout_o !== exp_word)
            begin
               errors++;
               $display("Fail at %0t: dout_o expected %h, got %h", $time, exp_word, dout_o);
            end
         end
      end
   end

   // AR monitor
   always @(negedge clk)
   begin
      if (ar_valid_o && ar_wait && ar_addr_o !== ar_prev)
      begin
         errors++;
         $display("Fail at %0t: ar_addr_o expected %h, got %h", $time, ar_prev, ar_addr_o);
      end
      if (ar_valid_o && ar_addr_o[P_LINE-1:0] != '0)
      begin
         errors++;
         $display("AR address %h at %0t is not line aligned", ar_addr_o, $time);
      end
      if (ar_valid_o && ar_ready_i)
      begin
         ar_count++;
         ar_last = ar_addr_o;
      end
      ar_wait = ar_valid_o & ~ar_ready_i;
      ar_prev = ar_addr_o;
   end

   // Holds the inputs until an edge where the cache is not stalled
   task automatic wait_accept();
      @(negedge clk);
      while (stall_o)
         @(negedge clk);
      @(posedge clk);
      #1;
   endtask

   task automatic issue_read(input logic [AW-1:0] a);
      int s;
      s      = a[P_LINE +: P_SETS];
      req_i  = 1'b1;
      addr_i = a;
      wait_accept();
      if (!tag_valid[s] || tag_line[s] != a[AW-1:P_LINE])
      begin
         misses++;
         tag_valid[s] = 1'b1;
         tag_line[s]  = a[AW-1:P_LINE];
         tag_gen[s]   = gen_ref[a[P_LINE +: 10]];
      end
      exp_q.push_back(ref_word(a, tag_gen[s]));
      reads++;
      req_i = 1'b0;
   endtask

   task automatic issue_inv(input logic [AW-1:0] a);
      inv_i      = 1'b1;
      inv_addr_i = a;
      wait_accept();
      tag_valid[a[P_LINE +: P_SETS]] = 1'b0;
      inv_i = 1'b0;
   endtask

   // New generation for the line in memory and in the reference
   task automatic make_stale(input logic [AW-1:0] a);
      @(negedge clk);
      gen_ref[a[P_LINE +: 10]]++;
      i_axi_mem.bump_gen(a);
      @(posedge clk);
      #1;
   endtask

   task automatic set_stalls(input logic on);
      @(negedge clk);
      stall_en = on;
      @(posedge clk);
      #1;
   endtask

   task automatic drain();
      while (exp_q.size() != 0)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic check_ar();
      if (ar_count != misses)
      begin
         errors++;
         $display("Fail at %0t: ar_valid_o handshakes expected %0d, got %0d",
                  $time, misses, ar_count);
      end
   endtask

   task automatic random_reads(input int n);
      logic [AW-1:0] a;
      for (int i = 0; i < n; i++)
      begin
         a = BASE + ($random(seed) & 32'h7FC);   // Twice the cache size
         issue_read(a);
      end
      drain();
      check_ar();
   endtask

   initial
   begin
      arst_n_i   = 1'b0;
      req_i      = 1'b0;
      addr_i     = '0;
      inv_i      = 1'b0;
      inv_addr_i = '0;
      stall_en   = 1'b0;
      repeat (5) @(posedge clk);
      if (valid_o || ar_valid_o || r_ready_o || !stall_o)
      begin
         errors++;
         $display("Outputs are not in their reset state during reset");
      end
      #1;
      arst_n_i = 1'b1;

      // Boot sweep
      @(negedge clk);
      while (stall_o)
      begin
         boot_cycles++;
         if (valid_o)
         begin
            errors++;
            $display("valid_o went high during the boot sweep at %0t", $time);
         end
         @(negedge clk);
      end
      if (boot_cycles != SETS)
      begin
         errors++;
         $display("Fail at %0t: stall_o boot cycles expected %0d, got %0d",
                  $time, SETS, boot_cycles);
      end
      @(posedge clk);
      #1;

      // Miss, then a hit in the same line
      issue_read(BASE + 32'h24);
      drain();
      check_ar();
      if (ar_last !== BASE + 32'h20)
      begin
         errors++;
         $display("Fail at %0t: ar_addr_o expected %h, got %h", $time, BASE + 32'h20, ar_last);
      end
      issue_read(BASE + 32'h28);
      @(negedge clk);
      @(negedge clk);
      if (!valid_o)
      begin
         errors++;
         $display("Hit result did not arrive two edges after acceptance");
      end
      @(posedge clk);
      #1;
      drain();
      check_ar();

      random_reads(N_RAND);
      set_stalls(1'b1);
      random_reads(N_RAND);

      // Stale data without invalidate, fresh data after it
      issue_read(BASE + 32'h108);
      drain();
      make_stale(BASE + 32'h108);
      issue_read(BASE + 32'h10C);
      drain();
      check_ar();
      issue_inv(BASE + 32'h100);
      for (int i = 0; i < 3; i++)
      begin
         @(negedge clk);
         if (stall_o != (i == 1))
         begin
            errors++;
            $display("stall_o around the invalidate at %0t is not a single cycle", $time);
         end
      end
      @(posedge clk);
      #1;
      issue_read(BASE + 32'h104);
      drain();
      check_ar();

      // Read right behind an invalidate of its own set
      issue_read(BASE + 32'h3F0);
      drain();
      make_stale(BASE + 32'h3F0);
      issue_inv(BASE + 32'h3F0);
      issue_read(BASE + 32'h3F4);
      drain();
      check_ar();

      if (results != reads)
      begin
         errors++;
         $display("Got %0d results for %0d reads", results, reads);
      end
      $display("Errors %0d, AR handshakes %0d, results %0d", errors, ar_count, results);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

//--- src.f
dc_pkg.sv
dc_sram.sv
dc_ctrl_fsm.sv
dc_line_counter.sv
dc_axi_rd.sv
dcache.sv
tb_axi_mem.sv
tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - dc_pkg.sv
  - dc_sram.sv
  - dc_ctrl_fsm.sv
  - dc_line_counter.sv
  - dc_axi_rd.sv
  - dcache.sv
  - target: test
    files:
      - tb_axi_mem.sv
      - tb_dcache.sv
